// ==== logic/host_pkg.sv ====
package host_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int ADDR_W     = 27;
	localparam int BEAT_W     = 16;
	localparam int WORD_W     = 32;
	localparam int PIF_ADDR_W = 10;

	// Cartridge image sits 8 MiB into the memory
	localparam logic [ADDR_W-1:0] CART_START = 27'd8388608;

	// Download index, low six bits
	localparam logic [5:0] IDX_BOOT = 6'd0;
	localparam logic [5:0] IDX_CART = 6'd1;

	// ========================================================================
	// Option word bit positions
	// ========================================================================

	localparam int OPT_RESET        = 0;
	localparam int OPT_BK_RELOAD    = 40;
	localparam int OPT_BK_SAVE      = 41;
	localparam int OPT_AUTOSAVE_OFF = 42;
	localparam int OPT_ASPECT_LO    = 47;
	localparam int OPT_ASPECT_HI    = 48;
	localparam int OPT_RAM_SIZE     = 70;
	localparam int OPT_SAVE_LO      = 75;
	localparam int OPT_SAVE_HI      = 77;
	localparam int OPT_REGION       = 79;

	// ========================================================================
	// Shared structs
	// ========================================================================

	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [BEAT_W-1:0] data;
	} dl_beat_t;

	typedef struct packed {
		logic                  en;
		logic [PIF_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} pif_write_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
	} cart_write_t;

	// EEPROM type 0 is none, 1 is 4 kbit and 2 is 16 kbit
	typedef struct packed {
		logic       pal;
		logic       ram_8mb;
		logic [1:0] eeprom_type;
		logic [2:0] save_type;
		logic       autosave;
	} host_options_t;

endpackage

// ==== logic/rom_download.sv ====
`timescale 1ns/10ps

module rom_download (
	input  logic                  clk_1x,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  host_pkg::dl_beat_t    dl_beat,
	input  logic                  cart_ready,
	output host_pkg::pif_write_t  pif_wr,
	output logic                  cart_req,
	output host_pkg::cart_write_t cart_wr,
	output logic                  dl_wait,
	output logic                  cart_download,
	output logic                  cart_loaded
);
	import host_pkg::*;

	logic                  pif_download;
	logic                  boot_beat;
	logic                  cart_beat;
	logic                  pif_en;
	logic [PIF_ADDR_W-1:0] pif_addr;
	logic [WORD_W-1:0]     pif_data;
	logic [ADDR_W-1:0]     cart_addr;
	logic [WORD_W-1:0]     cart_data;
	logic                  pending;

	// Beats only count once the mode register is set
	assign boot_beat = pif_download & dl_beat.wr;
	assign cart_beat = cart_download & dl_beat.wr;

	// ========================================================================
	// Mode registers, write strobes and pending flag
	// ========================================================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			pif_download  <= 1'b0;
			cart_download <= 1'b0;
			cart_loaded   <= 1'b0;
			pif_en        <= 1'b0;
			cart_req      <= 1'b0;
			pending       <= 1'b0;
		end else begin
			pif_download  <= dl_active & (dl_index[5:0] == IDX_BOOT);
			cart_download <= dl_active & (dl_index[5:0] == IDX_CART);
			pif_en        <= boot_beat & dl_beat.addr[1];
			cart_req      <= cart_beat & dl_beat.addr[1];
			if (cart_download) begin
				cart_loaded <= 1'b1;
			end
			// Memory took the word
			if (cart_ready) begin
				pending <= 1'b0;
			end
			if (cart_beat && dl_beat.addr[1]) begin
				pending <= 1'b1;
			end
		end
	end

	// ========================================================================
	// Word assembly
	// ========================================================================

	always_ff @(posedge clk_1x) begin
		if (boot_beat) begin
			// Boot ROM wants bytes swapped within each beat
			if (!dl_beat.addr[1]) begin
				pif_data[31:24] <= dl_beat.data[7:0];
				pif_data[23:16] <= dl_beat.data[15:8];
				pif_addr        <= {dl_index[6], dl_beat.addr[10:2]};
			end else begin
				pif_data[15:8] <= dl_beat.data[7:0];
				pif_data[7:0]  <= dl_beat.data[15:8];
			end
		end
		if (cart_beat) begin
			if (!dl_beat.addr[1]) begin
				cart_data[BEAT_W-1:0] <= dl_beat.data;
				cart_addr             <= dl_beat.addr + CART_START;
			end else begin
				cart_data[WORD_W-1:BEAT_W] <= dl_beat.data;
			end
		end
	end

	assign pif_wr  = '{en: pif_en, addr: pif_addr, data: pif_data};
	assign cart_wr = '{addr: cart_addr, data: cart_data};
	assign dl_wait = pending;

	a_no_beat_in_wait: assert property (@(posedge clk_1x) disable iff (reset)
		!(cart_beat && dl_wait))
		else $error("download beat accepted while dl_wait is high");

	a_single_flight: assert property (@(posedge clk_1x) disable iff (reset)
		cart_req |-> $past(!pending))
		else $error("cartridge request while a word is still pending");

endmodule

// ==== logic/backup_control.sv ====
`timescale 1ns/10ps

module backup_control (
	input  logic        clk_1x,
	input  logic        reset,
	input  logic        reload_opt,
	input  logic        save_opt,
	input  logic        autosave,
	input  logic        osd_open,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [31:0] img_size,
	output logic        bk_load,
	output logic        bk_save,
	output logic        use_img
);

	logic osd_prev;
	logic dl_prev;

	// ========================================================================
	// Load and save triggers
	// ========================================================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			osd_prev <= 1'b0;
			dl_prev  <= 1'b0;
			bk_load  <= 1'b0;
			bk_save  <= 1'b0;
			use_img  <= 1'b0;
		end else begin
			osd_prev <= osd_open;
			dl_prev  <= cart_download;
			bk_load  <= reload_opt | (cart_download & img_mounted);
			// Closing side of the menu is ignored, only the open edge saves
			bk_save  <= save_opt | (osd_open & ~osd_prev & autosave);

			// New cartridge drops the old save image
			if (cart_download && !dl_prev) begin
				use_img <= 1'b0;
			end
			if (img_mounted && (img_size != 32'd0) && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

	a_img_vs_dl_start: assert property (@(posedge clk_1x) disable iff (reset)
		!($rose(use_img) && $rose(cart_download)))
		else $error("use_img set as a cartridge download started");

endmodule

// ==== logic/option_decode.sv ====
`timescale 1ns/10ps

module option_decode (
	input  logic                    reset,
	input  logic                    reset_button,
	input  logic                    cart_download,
	input  logic [127:0]            options,
	output host_pkg::host_options_t settings,
	output logic                    reload_opt,
	output logic                    save_opt,
	output logic [12:0]             aspect_x,
	output logic [12:0]             aspect_y,
	output logic                    sys_reset
);
	import host_pkg::*;

	logic [1:0] aspect;
	logic [2:0] save_type;

	assign aspect    = options[OPT_ASPECT_HI:OPT_ASPECT_LO];
	assign save_type = options[OPT_SAVE_HI:OPT_SAVE_LO];

	// ========================================================================
	// Settings struct
	// ========================================================================

	always_comb begin
		settings.pal       = options[OPT_REGION];
		settings.ram_8mb   = ~options[OPT_RAM_SIZE];
		settings.save_type = save_type;
		settings.autosave  = ~options[OPT_AUTOSAVE_OFF];
		// Only the two EEPROM save types map through
		case (save_type)
			3'd1:    settings.eeprom_type = 2'd1;
			3'd2:    settings.eeprom_type = 2'd2;
			default: settings.eeprom_type = 2'd0;
		endcase
	end

	assign reload_opt = options[OPT_BK_RELOAD];
	assign save_opt   = options[OPT_BK_SAVE];

	// Code 0 is the native 4:3, others select a scaler preset
	assign aspect_x = (aspect == 2'd0) ? 13'd4 : {11'd0, aspect - 2'd1};
	assign aspect_y = (aspect == 2'd0) ? 13'd3 : 13'd0;

	// Core is held in reset while a cartridge loads
	assign sys_reset = reset | reset_button | options[OPT_RESET] | cart_download;

endmodule

// ==== logic/host_glue_top.sv ====
`timescale 1ns/10ps

module host_glue_top (
	input  logic                    clk_1x,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  host_pkg::dl_beat_t      dl_beat,
	input  logic                    cart_ready,
	input  logic [127:0]            options,
	input  logic                    reset_button,
	input  logic                    osd_open,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [31:0]             img_size,
	output host_pkg::pif_write_t    pif_wr,
	output logic                    cart_req,
	output host_pkg::cart_write_t   cart_wr,
	output logic                    dl_wait,
	output logic                    cart_loaded,
	output host_pkg::host_options_t settings,
	output logic [12:0]             aspect_x,
	output logic [12:0]             aspect_y,
	output logic                    sys_reset,
	output logic                    bk_load,
	output logic                    bk_save,
	output logic                    use_img
);

	logic cart_download;
	logic reload_opt;
	logic save_opt;

	// ========================================================================
	// Download path
	// ========================================================================

	rom_download u_rom_download (
		.clk_1x        (clk_1x),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_beat       (dl_beat),
		.cart_ready    (cart_ready),
		.pif_wr        (pif_wr),
		.cart_req      (cart_req),
		.cart_wr       (cart_wr),
		.dl_wait       (dl_wait),
		.cart_download (cart_download),
		.cart_loaded   (cart_loaded)
	);

	// ========================================================================
	// Options and backup
	// ========================================================================

	option_decode u_option_decode (
		.reset         (reset),
		.reset_button  (reset_button),
		.cart_download (cart_download),
		.options       (options),
		.settings      (settings),
		.reload_opt    (reload_opt),
		.save_opt      (save_opt),
		.aspect_x      (aspect_x),
		.aspect_y      (aspect_y),
		.sys_reset     (sys_reset)
	);

	backup_control u_backup_control (
		.clk_1x        (clk_1x),
		.reset         (reset),
		.reload_opt    (reload_opt),
		.save_opt      (save_opt),
		.autosave      (settings.autosave),
		.osd_open      (osd_open),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.use_img       (use_img)
	);

endmodule

// ==== sim/tb_host_glue.sv ====
`timescale 1ns/10ps

module tb_host_glue;
	import host_pkg::*;

	logic          clk_1x;
	logic          reset;
	logic          dl_active;
	logic [7:0]    dl_index;
	dl_beat_t      dl_beat;
	logic          cart_ready;
	logic [127:0]  options;
	logic          reset_button;
	logic          osd_open;
	logic          img_mounted;
	logic          img_readonly;
	logic [31:0]   img_size;
	pif_write_t    pif_wr;
	logic          cart_req;
	cart_write_t   cart_wr;
	logic          dl_wait;
	logic          cart_loaded;
	host_options_t settings;
	logic [12:0]   aspect_x;
	logic [12:0]   aspect_y;
	logic          sys_reset;
	logic          bk_load;
	logic          bk_save;
	logic          use_img;
	int            cycles;
	int            cycle_limit;
	logic [31:0]   lfsr_state;

	host_glue_top DUT (.*);

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	task automatic check(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// ========================================================================
	// Memory side and watchdog
	// ========================================================================

	initial begin
		logic [1:0]  delay;
		cart_write_t held;
		cart_ready <= 1'b0;
		lfsr_state = 32'hdb3a0ab8;
		forever begin
			@(posedge clk_1x);
			if (cart_req) begin
				held = cart_wr;
				lfsr_state = lfsr_next(lfsr_state);
				delay[0] = lfsr_state[0];
				lfsr_state = lfsr_next(lfsr_state);
				delay[1] = lfsr_state[0];
				repeat (delay) @(posedge clk_1x);
				// Word must not move while the memory is busy
				check("cart_wr held", 128'(held), 128'(cart_wr));
				cart_ready <= 1'b1;
				@(posedge clk_1x);
				cart_ready <= 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk_1x);
			cycles = cycles + 1;
			if (cycles > cycle_limit) begin
				$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
				$display("FAIL: see errors above");
				$fatal(1, "simulation timed out");
			end
		end
	end

	// ========================================================================
	// Trace operations
	// ========================================================================

	task automatic set_mode(input logic [7:0] index);
		@(posedge clk_1x);
		dl_active <= 1'b1;
		dl_index  <= index;
		repeat (2) @(posedge clk_1x);
	endtask

	task automatic send_beat(input logic [26:0] beat_addr, input logic [15:0] beat_data);
		dl_beat <= '{wr: 1'b1, addr: beat_addr, data: beat_data};
		@(posedge clk_1x);
	endtask

	task automatic boot_transfer(input logic [7:0] index, input logic [26:0] base,
			input logic [15:0] beat0, input logic [15:0] beat1,
			input logic [127:0] exp_addr, input logic [127:0] exp_data);
		set_mode(index);
		send_beat(base, beat0);
		send_beat(base + 27'd2, beat1);
		dl_beat.wr <= 1'b0;
		@(posedge clk_1x);
		while (!pif_wr.en) @(posedge clk_1x);
		check("boot address", exp_addr, 128'(pif_wr.addr));
		check("boot data", exp_data, 128'(pif_wr.data));
	endtask

	task automatic cart_transfer(input logic [26:0] base, input logic [15:0] beat0,
			input logic [15:0] beat1, input logic [127:0] exp_addr,
			input logic [127:0] exp_data);
		set_mode(8'h01);
		send_beat(base, beat0);
		send_beat(base + 27'd2, beat1);
		dl_beat.wr <= 1'b0;
		@(posedge clk_1x);
		while (!cart_req) @(posedge clk_1x);
		check("cart dl_wait", 128'd1, 128'(dl_wait));
		check("cart address", exp_addr, 128'(cart_wr.addr));
		check("cart data", exp_data, 128'(cart_wr.data));
		while (dl_wait) @(posedge clk_1x);
	endtask

	task automatic apply_options(input logic [127:0] word, input logic [127:0] exp_eeprom,
			input logic [127:0] exp_ax, input logic [127:0] exp_ay,
			input logic [127:0] exp_rst, input logic [127:0] exp_load);
		@(posedge clk_1x);
		options <= word;
		@(posedge clk_1x);
		check("eeprom_type", exp_eeprom, 128'(settings.eeprom_type));
		check("aspect_x", exp_ax, 128'(aspect_x));
		check("aspect_y", exp_ay, 128'(aspect_y));
		check("sys_reset", exp_rst, 128'(sys_reset));
		@(posedge clk_1x);
		check("option bk_load", exp_load, 128'(bk_load));
	endtask

	task automatic mount_image(input logic mounted, input logic readonly,
			input logic [31:0] size, input logic [127:0] exp_use,
			input logic [127:0] exp_load);
		@(posedge clk_1x);
		img_mounted  <= mounted;
		img_readonly <= readonly;
		img_size     <= size;
		@(posedge clk_1x);
		img_mounted <= 1'b0;
		@(posedge clk_1x);
		check("use_img", exp_use, 128'(use_img));
		check("image bk_load", exp_load, 128'(bk_load));
	endtask

	task automatic pulse_osd(input logic edge_in, input logic [127:0] exp_save);
		@(posedge clk_1x);
		osd_open <= edge_in;
		@(posedge clk_1x);
		osd_open <= 1'b0;
		@(posedge clk_1x);
		check("bk_save", exp_save, 128'(bk_save));
	endtask

	initial begin
		logic [127:0]     f [0:5];
		logic [8*8-1:0]   op;
		logic [8*160-1:0] text;
		int               fd;
		int               lines;
		int               code;
		reset        <= 1'b1;
		dl_active    <= 1'b0;
		dl_index     <= 8'h00;
		dl_beat      <= '0;
		options      <= '0;
		reset_button <= 1'b0;
		osd_open     <= 1'b0;
		img_mounted  <= 1'b0;
		img_readonly <= 1'b0;
		img_size     <= 32'd0;
		cycle_limit  = 200;
		fd = $fopen("sim/host_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file sim/host_trace.txt");
			$display("FAIL: see errors above");
			$fatal(1, "trace file missing");
		end
		// Budget of 40 cycles for each trace line
		lines = 0;
		while (!$feof(fd)) begin
			code = $fgets(text, fd);
			lines = lines + 1;
		end
		cycle_limit = 40 * lines + 200;
		$fclose(fd);
		fd = $fopen("sim/host_trace.txt", "r");

		repeat (16) @(posedge clk_1x);
		reset <= 1'b0;

		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				code = $fgets(text, fd);
			end else if (op == "BOOT") begin
				code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
				check("BOOT operand count", 128'd6, 128'(code));
				boot_transfer(f[0][7:0], f[1][26:0], f[2][15:0], f[3][15:0], f[4], f[5]);
			end else if (op == "CART") begin
				code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
				check("CART operand count", 128'd5, 128'(code));
				cart_transfer(f[0][26:0], f[1][15:0], f[2][15:0], f[3], f[4]);
			end else if (op == "OPT") begin
				code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
				check("OPT operand count", 128'd6, 128'(code));
				apply_options(f[0], f[1], f[2], f[3], f[4], f[5]);
			end else if (op == "IMG") begin
				code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
				check("IMG operand count", 128'd5, 128'(code));
				mount_image(f[0][0], f[1][0], f[2][31:0], f[3], f[4]);
			end else if (op == "OSD") begin
				code = $fscanf(fd, "%h %h", f[0], f[1]);
				check("OSD operand count", 128'd2, 128'(code));
				pulse_osd(f[0][0], f[1]);
			end else begin
				$display("Unknown opcode %0s in the trace file", op);
				$display("FAIL: see errors above");
				$fatal(1, "bad trace line");
			end
		end
		$fclose(fd);

		repeat (4) @(posedge clk_1x);
		check("cart_loaded", 128'd1, 128'(cart_loaded));
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== sim/host_trace.txt ====
# BOOT index addr beat0 beat1 exp_addr exp_data ; CART addr beat0 beat1 exp_addr exp_data
# OPT options exp_eeprom exp_aspect_x exp_aspect_y exp_sys_reset exp_bk_load
# IMG mounted readonly size exp_use_img exp_bk_load ; OSD edge exp_bk_save ; all hex
BOOT 00 0000000 1234 5678 000 34127856
BOOT 00 0000004 abcd ef01 001 cdab01ef
BOOT 40 00007fc 0f1e 2d3c 3ff 1e0f3c2d
BOOT 40 0000200 8001 00ff 280 0180ff00
OPT 00000000000000000000000000000000 0 4 3 0 0
OPT 00000000000008000000800000000000 1 0 0 0 0
OPT 00000000000010000001000000000001 2 1 0 1 0
OPT 00000000000028000001850000000000 0 2 0 0 1
OSD 1 0
OPT 00000000000000000000000000000000 0 4 3 0 0
OSD 1 1
OSD 0 0
IMG 1 1 00004000 0 0
IMG 1 0 00000000 0 0
IMG 1 0 00004000 1 0
CART 0000000 aaaa 5555 0800000 5555aaaa
CART 0000004 1357 2468 0800004 24681357
CART 0000008 dead beef 0800008 beefdead
CART 000000c 0001 8000 080000c 80000001
CART 7fffff0 cafe f00d 07ffff0 f00dcafe
CART 1234568 0102 0304 1a34568 03040102
IMG 0 0 00000000 0 0
IMG 1 1 00000800 0 1
OPT 00000000000000000000000000000000 0 4 3 1 0
BOOT 00 0000010 1111 2222 004 11112222

// ==== vlog.f ====
logic/host_pkg.sv
logic/rom_download.sv
logic/backup_control.sv
logic/option_decode.sv
logic/host_glue_top.sv
sim/tb_host_glue.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module host_glue_top -f vlog.f

sim:
	verilator --binary --timing --assert --top-module tb_host_glue -f vlog.f -o sim_host_glue
	./obj_dir/sim_host_glue | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
